// ==== hdl/mmio_consts.svh ====
// Tag, address, register count and bank wait-state constants for the MMIO subsystem
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// Tag width, which allows 16 reads in flight at once
`define MMIO_TAG_BITS 4

// Byte address width of a host MMIO request
// Bit 9 picks the bank and bits 7:3 pick the register
`define MMIO_ADDR_BITS 10

// Number of 64-bit registers in each bank
`define CSR_REGS 32

// Extra cycles the slow bank spends before it completes a command
`define SLOW_BANK_WAIT 3

`endif

// ==== hdl/mmio_pkg.sv ====
// Host request, read tracking, AFU response and bank command types
`default_nettype none

`include "mmio_consts.svh"

package mmio_pkg;

    // Tag of a host read, also used to index the completion tag table
    typedef logic [`MMIO_TAG_BITS-1:0] mmio_tag_t;
    // Byte address of a host request
    typedef logic [`MMIO_ADDR_BITS-1:0] mmio_addr_t;
    typedef logic [15:0] req_id_t;
    // Byte count of a request, either 4 or 8
    typedef logic [11:0] byte_cnt_t;
    typedef logic [63:0] csr_data_t;
    // Register index inside one bank
    typedef logic [$clog2(`CSR_REGS)-1:0] reg_idx_t;
    // Low address bits that a completion reports back
    typedef logic [6:0] lower_addr_t;

    // One request as the host presents it
    typedef struct packed {
        mmio_tag_t tag;
        req_id_t   req_id;
        mmio_addr_t addr;
        byte_cnt_t byte_cnt;
        logic      wr;
        csr_data_t wr_data;
    } mmio_host_req_t;

    // Details of a read that the completion needs later
    typedef struct packed {
        mmio_tag_t   tag;
        req_id_t     req_id;
        byte_cnt_t   byte_cnt;
        lower_addr_t lower_addr;
    } mmio_rd_meta_t;

    // Read data from a bank, still carrying the tag of its request
    typedef struct packed {
        mmio_tag_t tag;
        csr_data_t payload;
    } mmio_afu_rsp_t;

    // Command held on a bank channel while its req is high
    typedef struct packed {
        reg_idx_t  idx;
        logic      wr;
        csr_data_t wr_data;
        mmio_tag_t tag;
    } bank_req_t;

endpackage

`default_nettype wire

// ==== hdl/tlp_pkg.sv ====
// Completion TLP format type, header and full completion types
`default_nettype none

package tlp_pkg;

    // Header field widths follow the completion header layout
    typedef logic [9:0]  tlp_len_t;
    typedef logic [11:0] tlp_byte_cnt_t;
    typedef logic [15:0] tlp_req_id_t;
    typedef logic [6:0]  tlp_lower_addr_t;
    typedef logic [7:0]  tlp_tag_t;
    typedef logic [63:0] tlp_payload_t;

    // Format and type byte of a TLP
    // Only completion with data leaves this subsystem
    typedef enum logic [7:0] {
        FMTTYPE_MRD32 = 8'h00,
        FMTTYPE_MWR32 = 8'h40,
        FMTTYPE_CPL   = 8'h0a,
        FMTTYPE_CPLD  = 8'h4a
    } tlp_fmttype_t;

    typedef struct packed {
        tlp_fmttype_t    fmttype;
        tlp_len_t        length;
        tlp_byte_cnt_t   byte_count;
        tlp_req_id_t     requester_id;
        tlp_lower_addr_t lower_addr;
        tlp_tag_t        tag;
    } tlp_cpl_hdr_t;

    // One completion is a header and a single 64-bit payload
    typedef struct packed {
        tlp_cpl_hdr_t hdr;
        tlp_payload_t payload;
    } cpl_tlp_t;

endpackage

`default_nettype wire

// ==== hdl/mmio_req_router.sv ====
// Host request router that dispatches to two banks over four-phase req/ack
`timescale 1ns/1ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_req_router import mmio_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  mmio_host_req_t       host_req,
    input  logic                 host_req_valid,
    output logic                 host_req_ready,

    output mmio_rd_meta_t        rd_track,
    output logic                 rd_track_valid,

    output bank_req_t [1:0]      bank_cmd,
    output logic [1:0]           bank_req,
    input  logic [1:0]           bank_ack
);

    // Phases of one bank channel
    typedef enum logic [1:0] {
        CH_IDLE,
        CH_REQ,
        CH_WAIT_DROP
    } ch_state_t;

    ch_state_t ch_state [2];
    logic      running;
    logic      sel;
    logic      accept;

    // The top address bit names the target bank
    assign sel = host_req.addr[`MMIO_ADDR_BITS-1];

    // Ready stays low until the first edge after reset is released
    assign host_req_ready = running && (ch_state[sel] == CH_IDLE);
    assign accept = host_req_valid && host_req_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            running <= 1'b0;
            rd_track_valid <= 1'b0;
            ch_state[0] <= CH_IDLE;
            ch_state[1] <= CH_IDLE;
        end
        else
        begin
            running <= 1'b1;
            // Only reads are tracked, so writes never reach the tag table
            rd_track_valid <= accept && !host_req.wr;

            for (int b = 0; b < 2; b++)
            begin
                case (ch_state[b])
                    CH_IDLE:
                        if (accept && (sel == b[0]))
                            ch_state[b] <= CH_REQ;
                    // Req is held until the bank says its work is done
                    CH_REQ:
                        if (bank_ack[b])
                            ch_state[b] <= CH_WAIT_DROP;
                    // The channel is free only once ack has fallen again
                    CH_WAIT_DROP:
                        if (!bank_ack[b])
                            ch_state[b] <= CH_IDLE;
                    default:
                        ch_state[b] <= CH_IDLE;
                endcase
            end
        end
    end

    // Command and read details are captured at accept and held stable
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            bank_cmd[sel].idx <= host_req.addr[3 +: $bits(reg_idx_t)];
            bank_cmd[sel].wr <= host_req.wr;
            bank_cmd[sel].wr_data <= host_req.wr_data;
            bank_cmd[sel].tag <= host_req.tag;

            rd_track.tag <= host_req.tag;
            rd_track.req_id <= host_req.req_id;
            rd_track.byte_cnt <= host_req.byte_cnt;
            rd_track.lower_addr <= host_req.addr[6:0];
        end
    end

    assign bank_req[0] = (ch_state[0] == CH_REQ);
    assign bank_req[1] = (ch_state[1] == CH_REQ);

endmodule

`default_nettype wire

// ==== hdl/csr_bank.sv ====
// Register bank with wait states, four-phase command channel and read response
`timescale 1ns/1ps
`default_nettype none

`include "mmio_consts.svh"

module csr_bank import mmio_pkg::*;
#(
    parameter int WAIT_STATES = 0
)
(
    input  logic          clk,
    input  logic          reset_n,

    input  bank_req_t     bank_cmd,
    input  logic          bank_req,
    output logic          bank_ack,

    output mmio_afu_rsp_t rsp,
    output logic          rsp_valid,
    input  logic          rsp_ready
);

    // Counter must stay at least one bit wide even with no wait states
    localparam int CNT_BITS = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

    typedef enum logic [1:0] {
        B_IDLE,
        B_WAIT,
        B_RSP,
        B_ACK
    } bank_state_t;

    bank_state_t         state;
    logic [CNT_BITS-1:0] wait_cnt;
    logic                do_op;
    csr_data_t           regs [`CSR_REGS];

    // The command is carried out in the cycle its last wait state ends
    // A bank without wait states acts on the first cycle req is seen
    assign do_op = bank_req &&
                   ((state == B_IDLE && WAIT_STATES == 0) ||
                    (state == B_WAIT && wait_cnt == CNT_BITS'(WAIT_STATES - 1)));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= B_IDLE;
            wait_cnt <= '0;
            bank_ack <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            case (state)
                B_IDLE:
                    if (bank_req && !do_op)
                    begin
                        state <= B_WAIT;
                        wait_cnt <= '0;
                    end
                B_WAIT:
                    if (!do_op)
                        wait_cnt <= wait_cnt + 1'b1;
                // A read acks only once its data has left the bank
                B_RSP:
                    if (rsp_ready)
                    begin
                        rsp_valid <= 1'b0;
                        bank_ack <= 1'b1;
                        state <= B_ACK;
                    end
                B_ACK:
                    if (!bank_req)
                    begin
                        bank_ack <= 1'b0;
                        state <= B_IDLE;
                    end
                default:
                    state <= B_IDLE;
            endcase

            // Writes ack at once and reads first present their data
            if (do_op)
            begin
                if (bank_cmd.wr)
                begin
                    bank_ack <= 1'b1;
                    state <= B_ACK;
                end
                else
                begin
                    rsp_valid <= 1'b1;
                    state <= B_RSP;
                end
            end
        end
    end

    // Every register reads as zero after reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            regs <= '{default: '0};
        else if (do_op && bank_cmd.wr)
            regs[bank_cmd.idx] <= bank_cmd.wr_data;
    end

    // Response payload is loaded once and held until it is taken
    always_ff @(posedge clk)
    begin
        if (do_op && !bank_cmd.wr)
        begin
            rsp.tag <= bank_cmd.tag;
            rsp.payload <= regs[bank_cmd.idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rsp_arbiter.sv ====
// Round-robin merge of the two bank response streams onto one AFU stream
`timescale 1ns/1ps
`default_nettype none

module rsp_arbiter import mmio_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,

    input  mmio_afu_rsp_t [1:0] in_rsp,
    input  logic [1:0]          in_valid,
    output logic [1:0]          in_ready,

    output mmio_afu_rsp_t       out_rsp,
    output logic                out_valid,
    input  logic                out_ready
);

    logic last_grant;
    logic hold;
    logic grant;

    // A response left waiting keeps its grant until it is taken
    // Otherwise a tie goes to the bank that was not served last
    always_comb
    begin
        if (hold)
            grant = last_grant;
        else if (in_valid[0] && in_valid[1])
            grant = ~last_grant;
        else
            grant = in_valid[1];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // Bank 0 wins the first tie
            last_grant <= 1'b1;
            hold <= 1'b0;
        end
        else if (out_valid)
        begin
            last_grant <= grant;
            hold <= !out_ready;
        end
        else
        begin
            hold <= 1'b0;
        end
    end

    assign out_rsp = in_rsp[grant];
    assign out_valid = in_valid[grant];

    // Only the granted bank sees ready, so the other keeps its data
    assign in_ready[0] = out_ready && !grant;
    assign in_ready[1] = out_ready && grant;

endmodule

`default_nettype wire

// ==== hdl/cpl_fifo2.sv ====
// Two-entry FIFO with registered occupancy and notFull/notEmpty flags
`timescale 1ns/1ps
`default_nettype none

module cpl_fifo2
#(
    parameter int DATA_BITS = 64
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic [DATA_BITS-1:0] enq_data,
    input  logic                 enq_en,
    output logic                 not_full,

    output logic [DATA_BITS-1:0] first,
    input  logic                 deq_en,
    output logic                 not_empty
);

    logic [DATA_BITS-1:0] mem [2];
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= ~wr_ptr;
            if (deq_en)
                rd_ptr <= ~rd_ptr;
            // Enqueue and dequeue together leave the count unchanged
            count <= count + {1'b0, enq_en} - {1'b0, deq_en};
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    assign first = mem[rd_ptr];
    assign not_full = (count != 2'd2);
    assign not_empty = (count != 2'd0);

endmodule

`default_nettype wire

// ==== hdl/mmio_cpl_gen.sv ====
// Completion generator with read tag table, response FIFO and registered TLP output
`timescale 1ns/1ps
`default_nettype none

module mmio_cpl_gen import mmio_pkg::*, tlp_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,

    input  mmio_rd_meta_t rd_track,
    input  logic          rd_track_valid,

    input  mmio_afu_rsp_t afu_rsp,
    input  logic          afu_rsp_valid,
    output logic          afu_rsp_ready,

    output cpl_tlp_t      cpl,
    output logic          cpl_valid,
    input  logic          cpl_ready
);

    localparam int TAGS = 1 << $bits(mmio_tag_t);
    localparam int ENTRY_BITS = $bits(mmio_afu_rsp_t) + $bits(mmio_rd_meta_t);

    // Details of every outstanding read, indexed by its tag
    mmio_rd_meta_t tag_table [TAGS];
    mmio_rd_meta_t afu_rsp_meta;

    mmio_afu_rsp_t fifo_rsp;
    mmio_rd_meta_t fifo_meta;
    logic          fifo_deq;
    logic          fifo_not_empty;
    logic          out_free;
    tlp_cpl_hdr_t  cpl_hdr;

    // The table always accepts, since a tag is reused only after it completes
    always_ff @(posedge clk)
    begin
        if (rd_track_valid)
            tag_table[rd_track.tag] <= rd_track;
    end

    // Look up the original read while the response is on the bus
    assign afu_rsp_meta = tag_table[afu_rsp.tag];

    // Response and its read details travel together through the FIFO
    // A full FIFO pushes back on the arbiter and so on the banks
    cpl_fifo2
    #(
        .DATA_BITS(ENTRY_BITS)
    )
    rsp_fifo
    (
        .clk,
        .reset_n,
        .enq_data({afu_rsp, afu_rsp_meta}),
        .enq_en(afu_rsp_valid && afu_rsp_ready),
        .not_full(afu_rsp_ready),
        .first({fifo_rsp, fifo_meta}),
        .deq_en(fifo_deq),
        .not_empty(fifo_not_empty)
    );

    // The output register may load when empty or when its TLP is taken
    assign out_free = cpl_ready || !cpl_valid;
    assign fifo_deq = fifo_not_empty && out_free;

    // Header of a completion with data for the oldest response
    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr.fmttype = FMTTYPE_CPLD;
        // Length counts dwords, so 4 bytes give 1 and 8 bytes give 2
        cpl_hdr.length = tlp_len_t'(fifo_meta.byte_cnt >> 2);
        cpl_hdr.byte_count = fifo_meta.byte_cnt;
        cpl_hdr.requester_id = fifo_meta.req_id;
        cpl_hdr.lower_addr = fifo_meta.lower_addr;
        cpl_hdr.tag = tlp_tag_t'(fifo_rsp.tag);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            cpl_valid <= 1'b0;
        else if (out_free)
            cpl_valid <= fifo_not_empty;
    end

    // Payload and header hold while the host holds off ready
    always_ff @(posedge clk)
    begin
        if (fifo_deq)
        begin
            cpl.hdr <= cpl_hdr;
            cpl.payload <= fifo_rsp.payload;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mmio_subsys_top.sv ====
// MMIO subsystem top level with router, two CSR banks, arbiter and completion generator
`timescale 1ns/1ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_subsys_top import mmio_pkg::*, tlp_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,

    input  mmio_host_req_t host_req,
    input  logic           host_req_valid,
    output logic           host_req_ready,

    output cpl_tlp_t       cpl,
    output logic           cpl_valid,
    input  logic           cpl_ready
);

    mmio_rd_meta_t        rd_track;
    logic                 rd_track_valid;

    bank_req_t [1:0]      bank_cmd;
    logic [1:0]           bank_req;
    logic [1:0]           bank_ack;

    mmio_afu_rsp_t [1:0]  bank_rsp;
    logic [1:0]           bank_rsp_valid;
    logic [1:0]           bank_rsp_ready;

    // Single response stream shared by both banks
    mmio_afu_rsp_t        afu_rsp;
    logic                 afu_rsp_valid;
    logic                 afu_rsp_ready;

    mmio_req_router router
    (
        .clk,
        .reset_n,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .rd_track,
        .rd_track_valid,
        .bank_cmd,
        .bank_req,
        .bank_ack
    );

    // Bank 0 answers at once, bank 1 is the slow peer
    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        csr_bank
        #(
            .WAIT_STATES((b == 0) ? 0 : `SLOW_BANK_WAIT)
        )
        bank
        (
            .clk,
            .reset_n,
            .bank_cmd(bank_cmd[b]),
            .bank_req(bank_req[b]),
            .bank_ack(bank_ack[b]),
            .rsp(bank_rsp[b]),
            .rsp_valid(bank_rsp_valid[b]),
            .rsp_ready(bank_rsp_ready[b])
        );
    end

    rsp_arbiter arbiter
    (
        .clk,
        .reset_n,
        .in_rsp(bank_rsp),
        .in_valid(bank_rsp_valid),
        .in_ready(bank_rsp_ready),
        .out_rsp(afu_rsp),
        .out_valid(afu_rsp_valid),
        .out_ready(afu_rsp_ready)
    );

    mmio_cpl_gen cpl_gen
    (
        .clk,
        .reset_n,
        .rd_track,
        .rd_track_valid,
        .afu_rsp,
        .afu_rsp_valid,
        .afu_rsp_ready,
        .cpl,
        .cpl_valid,
        .cpl_ready
    );

endmodule

`default_nettype wire

// ==== verif/mmio_asserts.sv ====
// Bound concurrent checks on read tag usage, completion stability and bank req/ack
`timescale 1ns/1ps
`default_nettype none

module mmio_asserts import mmio_pkg::*, tlp_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,

    input  mmio_rd_meta_t rd_track,
    input  logic          rd_track_valid,
    input  mmio_afu_rsp_t afu_rsp,
    input  logic          afu_rsp_valid,
    input  cpl_tlp_t      cpl,
    input  logic          cpl_valid,
    input  logic          cpl_ready,

    input  logic [1:0]    bank_req,
    input  logic [1:0]    bank_ack
);

    // Each tag has a bit that its tracking record sets and its completion clears
    logic [(1 << $bits(mmio_tag_t))-1:0] active;
    mmio_tag_t                           cpl_tag;

    assign cpl_tag = mmio_tag_t'(cpl.hdr.tag);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            active <= '0;
        else
        begin
            if (cpl_valid && cpl_ready)
                active[cpl_tag] <= 1'b0;
            if (rd_track_valid)
                active[rd_track.tag] <= 1'b1;
        end
    end

    // A tag may only be tracked again once its completion has left
    a_track_free: assert property (@(posedge clk) disable iff (!reset_n)
        rd_track_valid |-> !active[rd_track.tag])
        else $error("Tracking record for tag %0d that is still active", rd_track.tag);

    // Bank data must belong to a read that is still outstanding
    a_rsp_active: assert property (@(posedge clk) disable iff (!reset_n)
        afu_rsp_valid |-> active[afu_rsp.tag])
        else $error("AFU response for inactive tag %0d", afu_rsp.tag);

    // A stalled completion holds both its valid and its contents
    a_cpl_stable: assert property (@(posedge clk) disable iff (!reset_n)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl))
        else $error("Completion changed while stalled");

    for (genvar b = 0; b < 2; b++)
    begin : g_chan
        // Under the four-phase rule req stays up until the bank acks
        a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
            bank_req[b] && !bank_ack[b] |=> bank_req[b])
            else $error("Bank %0d request dropped before its ack", b);
    end

endmodule

// Tag and completion checks sit on the completion generator
bind mmio_cpl_gen mmio_asserts cpl_gen_checks
(
    .clk,
    .reset_n,
    .rd_track,
    .rd_track_valid,
    .afu_rsp,
    .afu_rsp_valid,
    .cpl,
    .cpl_valid,
    .cpl_ready,
    .bank_req(2'b00),
    .bank_ack(2'b00)
);

// Channel checks sit on the router
bind mmio_req_router mmio_asserts router_checks
(
    .clk,
    .reset_n,
    .rd_track('0),
    .rd_track_valid(1'b0),
    .afu_rsp('0),
    .afu_rsp_valid(1'b0),
    .cpl('0),
    .cpl_valid(1'b0),
    .cpl_ready(1'b0),
    .bank_req,
    .bank_ack
);

`default_nettype wire

// ==== verif/mmio_tb.sv ====
// Testbench for the MMIO subsystem with register model, tag pool, random traffic and summary
`timescale 1ns/1ps
`default_nettype none

`include "mmio_consts.svh"

module mmio_tb import mmio_pkg::*, tlp_pkg::*;
();

    localparam int TAGS = 1 << `MMIO_TAG_BITS;
    // Request count summed over the reset, write-read, concurrent, back-pressure and write tests
    localparam int N_REQS = 8 + 48 + 24 + 40 + 16;
    localparam int CYCLE_LIMIT = 40 * N_REQS + 200;

    logic           clk;
    logic           reset_n;
    mmio_host_req_t host_req;
    logic           host_req_valid;
    logic           host_req_ready;
    cpl_tlp_t       cpl;
    logic           cpl_valid;
    logic           cpl_ready;

    // Register model of both banks with the bank bit above the register index
    csr_data_t    model_regs [2 * `CSR_REGS];
    mmio_tag_t    free_tags [$];
    logic         exp_busy [TAGS];
    tlp_cpl_hdr_t exp_hdr [TAGS];
    csr_data_t    exp_data [TAGS];
    string        exp_test [TAGS];

    logic bp_pattern [1024];
    logic bp_en;
    logic quiet;
    int   cycles;
    int   reads_issued;
    int   cpl_count;
    int   mismatch_cnt;
    int   other_cnt;

    mmio_subsys_top DUT
    (
        .clk,
        .reset_n,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .cpl,
        .cpl_valid,
        .cpl_ready
    );

    always #50 clk = ~clk;

    function automatic int reg_index(input mmio_addr_t a);
        return int'({a[9], a[7:3]});
    endfunction

    // Random address in one bank that is aligned to the byte count
    function automatic mmio_addr_t rand_addr(input logic bank, input byte_cnt_t cnt);
        mmio_addr_t a;
        a = mmio_addr_t'($urandom);
        a[9] = bank;
        a[1:0] = 2'b00;
        if (cnt == 12'd8)
            a[2] = 1'b0;
        return a;
    endfunction

    task automatic check_hdr(input string name, input tlp_cpl_hdr_t exp, input tlp_cpl_hdr_t act);
        if (act !== exp)
        begin
            mismatch_cnt++;
            $display("Fail %s: header expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp)
        begin
            mismatch_cnt++;
            $display("Fail %s: payload expected %h, actual %h", name, exp, act);
        end
    endtask

    // Holds the request until the DUT takes it; ready is sampled in the low half
    task automatic send_req(input mmio_host_req_t r);
        logic taken;
        host_req = r;
        host_req_valid = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            taken = host_req_ready;
            @(posedge clk);
            #1;
        end
        host_req_valid = 1'b0;
    endtask

    task automatic issue_write(input mmio_addr_t addr);
        mmio_host_req_t r;
        r.tag = '0;
        r.req_id = req_id_t'($urandom);
        r.addr = addr;
        r.byte_cnt = 12'd8;
        r.wr = 1'b1;
        r.wr_data = {$urandom, $urandom};
        // A write always replaces the whole register
        model_regs[reg_index(addr)] = r.wr_data;
        send_req(r);
    endtask

    task automatic issue_read(input mmio_addr_t addr, input byte_cnt_t cnt, input string name);
        mmio_host_req_t r;
        mmio_tag_t      t;
        tlp_cpl_hdr_t   h;
        while (free_tags.size() == 0)
        begin
            @(posedge clk);
            #1;
        end
        t = free_tags.pop_front();
        r.tag = t;
        r.req_id = req_id_t'($urandom);
        r.addr = addr;
        r.byte_cnt = cnt;
        r.wr = 1'b0;
        r.wr_data = '0;
        // The expected header is a completion with data whose length is in dwords
        // Its lower address is the low seven address bits
        h = '0;
        h.fmttype = FMTTYPE_CPLD;
        h.length = tlp_len_t'(cnt / 4);
        h.byte_count = cnt;
        h.requester_id = r.req_id;
        h.lower_addr = addr[6:0];
        h.tag = tlp_tag_t'(t);
        exp_hdr[t] = h;
        exp_data[t] = model_regs[reg_index(addr)];
        exp_test[t] = name;
        exp_busy[t] = 1'b1;
        reads_issued++;
        send_req(r);
    endtask

    task automatic handle_cpl(input cpl_tlp_t c);
        int t;
        t = int'(c.hdr.tag);
        cpl_count++;
        if (quiet)
        begin
            other_cnt++;
            $display("A completion appeared while only writes were in flight");
        end
        if (t >= TAGS || !exp_busy[t])
        begin
            other_cnt++;
            $display("Completion with tag %0d arrived but no read with that tag was open", t);
        end
        else
        begin
            check_hdr(exp_test[t], exp_hdr[t], c.hdr);
            check_data(exp_test[t], exp_data[t], c.payload);
            exp_busy[t] = 1'b0;
            free_tags.push_back(mmio_tag_t'(t));
        end
    endtask

    task automatic wait_drain();
        while (free_tags.size() != TAGS)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Completions are taken in the low half, where valid, data and ready are stable
    always @(negedge clk)
    begin
        if (reset_n && cpl_valid && cpl_ready)
            handle_cpl(cpl);
    end

    always @(posedge clk)
    begin
        #1;
        cpl_ready = bp_en ? bp_pattern[cycles % 1024] : 1'b1;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles before the tests finished", cycles);
            for (int t = 0; t < TAGS; t++)
                if (exp_busy[t])
                    $display("Tag %0d never completed", t);
            $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt + 1);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        logic       bank;
        byte_cnt_t  cnt;
        mmio_addr_t a;
        mmio_addr_t wr_addrs [$];

        void'($urandom(32'h3328));
        clk = 1'b0;
        reset_n = 1'b0;
        host_req = '0;
        host_req_valid = 1'b0;
        cpl_ready = 1'b1;
        bp_en = 1'b0;
        quiet = 1'b0;
        cycles = 0;
        reads_issued = 0;
        cpl_count = 0;
        mismatch_cnt = 0;
        other_cnt = 0;
        for (int i = 0; i < 2 * `CSR_REGS; i++)
            model_regs[i] = '0;
        for (int t = 0; t < TAGS; t++)
        begin
            exp_busy[t] = 1'b0;
            free_tags.push_back(mmio_tag_t'(t));
        end
        // Ready is low on about half of the back-pressure cycles
        for (int i = 0; i < 1024; i++)
            bp_pattern[i] = 1'($urandom & 1);

        repeat (2) @(posedge clk);
        #1;
        // The host may not be taken and no completion may show while reset is held
        if (host_req_ready !== 1'b0 || cpl_valid !== 1'b0)
        begin
            other_cnt++;
            $display("Request ready or completion valid was high during reset");
        end
        reset_n = 1'b1;

        // Registers read as zero before any write
        for (int i = 0; i < 8; i++)
        begin
            cnt = ($urandom & 1) ? 12'd8 : 12'd4;
            issue_read(rand_addr(i[0], cnt), cnt, "reset_values");
        end
        wait_drain();

        for (int i = 0; i < 24; i++)
        begin
            a = rand_addr(1'($urandom & 1), 12'd8);
            wr_addrs.push_back(a);
            issue_write(a);
        end
        foreach (wr_addrs[i])
        begin
            cnt = ($urandom & 1) ? 12'd8 : 12'd4;
            a = wr_addrs[i];
            if (cnt == 12'd4)
                a[2] = 1'($urandom & 1);
            issue_read(a, cnt, "write_read");
        end
        wait_drain();

        // Alternating banks keep both channels and the arbiter busy
        for (int i = 0; i < 24; i++)
            issue_read(rand_addr(i[0], 12'd8), 12'd8, "concurrent_banks");
        wait_drain();

        bp_en = 1'b1;
        for (int i = 0; i < 40; i++)
        begin
            bank = 1'($urandom & 1);
            if ($urandom & 1)
                issue_write(rand_addr(bank, 12'd8));
            else
                issue_read(rand_addr(bank, 12'd8), 12'd8, "back_pressure");
        end
        wait_drain();
        bp_en = 1'b0;

        // Nothing may come back while only writes run and drain
        quiet = 1'b1;
        for (int i = 0; i < 16; i++)
            issue_write(rand_addr(1'($urandom & 1), 12'd8));
        repeat (100) @(posedge clk);
        #1;
        quiet = 1'b0;

        if (cpl_count != reads_issued)
        begin
            other_cnt++;
            $display("Got %0d completions for %0d reads", cpl_count, reads_issued);
        end
        $display("Summary: %0d reads, %0d completions, %0d mismatches, %0d other errors",
                 reads_issued, cpl_count, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/mmio_pkg.sv
hdl/tlp_pkg.sv
hdl/mmio_req_router.sv
hdl/csr_bank.sv
hdl/rsp_arbiter.sv
hdl/cpl_fifo2.sv
hdl/mmio_cpl_gen.sv
hdl/mmio_subsys_top.sv
verif/mmio_asserts.sv
verif/mmio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MMIO subsystem testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module mmio_tb -f files.f -o mmio_sim &&
./obj_dir/mmio_sim | tee /dev/stderr | grep -q "^No errors$" &&
echo "Simulation passed" ||
{
    echo "Simulation failed"
    exit 1
}
